//--- hw/bus_frame_pkg.sv
// word, address, id and bit count types plus the config frame struct
`include "serial_slave_defines.svh"

package bus_frame_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_t;

    typedef logic [$clog2(`ADDR_DEPTH)-1:0] addr_t;

    typedef logic [`SLAVE_ID_WIDTH-1:0] slave_id_t;

    // wide enough to hold DATA_WIDTH itself
    typedef logic [$clog2(`DATA_WIDTH):0] bit_count_t;

    typedef logic [$bits(`START_CODE)-1:0] start_t;

    // frame order, MSB sent first
    typedef struct packed {
        start_t    start;
        slave_id_t id;
        logic      rw;
        logic      burst;
        addr_t     addr;
    } bus_cmd_t;

endpackage

//--- hw/config_receiver.sv
// config_receiver module: config frame shift register and slave match
`timescale 1ns/1ps
`include "serial_slave_defines.svh"

module config_receiver #(
    parameter bus_frame_pkg::slave_id_t SLAVE_ID = 2'd1
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    control,
    input  logic                    busy,
    output bus_frame_pkg::bus_cmd_t cmd,
    output logic                    cmd_valid
);
    import bus_frame_pkg::*;

    localparam int FRAME_BITS = $bits(bus_cmd_t);
    localparam int CNT_W = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] frame;
    logic [FRAME_BITS-1:0] frame_next;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  receiving;
    logic                  frame_start;
    logic                  frame_end;
    bus_cmd_t              frame_cmd;

    // first high control bit in idle is the frame MSB
    assign frame_start = !receiving && !busy && !cmd_valid && control;
    assign frame_end   = receiving && (bit_cnt == CNT_W'(FRAME_BITS - 1));
    assign frame_next  = {frame[FRAME_BITS-2:0], control};
    assign frame_cmd   = bus_cmd_t'(frame_next);
    assign cmd         = bus_cmd_t'(frame);

    always_ff @(posedge clk) begin
        if (frame_start || receiving) begin
            frame <= frame_next;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            receiving <= 1'b0;
            bit_cnt   <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (frame_start) begin
                receiving <= 1'b1;
                bit_cnt   <= CNT_W'(1);
            end else if (receiving) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (frame_end) begin
                    receiving <= 1'b0;
                    bit_cnt   <= '0;
                    // foreign or broken frames are dropped here
                    cmd_valid <= (frame_cmd.start == `START_CODE) &&
                                 (frame_cmd.id == SLAVE_ID);
                end
            end
        end
    end

    // the controller must still be idle when a command lands
    a_no_cmd_when_busy: assert property (
        @(posedge clk) disable iff (!rstN) cmd_valid |-> !busy
    );

endmodule

//--- hw/read_serializer.sv
// read_serializer module: loaded word shifted out on rD, MSB first
`timescale 1ns/1ps
`include "serial_slave_defines.svh"

module read_serializer (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 load,
    input  bus_frame_pkg::data_t load_data,
    output logic                 rD,
    output logic                 word_sent
);
    import bus_frame_pkg::*;

    data_t      shift_reg;
    bit_count_t bit_cnt;
    logic       active;

    // rD rests low between words
    assign rD        = active && shift_reg[`DATA_WIDTH-1];
    assign word_sent = active && (bit_cnt == bit_count_t'(`DATA_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= load_data;
        end else if (active) begin
            shift_reg <= shift_reg << 1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (load) begin
            active  <= 1'b1;
            bit_cnt <= '0;
        end else if (active) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (word_sent) begin
                active <= 1'b0;
            end
        end
    end

    // reload only once the current word is on its final bit
    a_load_when_free: assert property (
        @(posedge clk) disable iff (!rstN) load |-> (!active || word_sent)
    );

endmodule

//--- hw/serial_slave.sv
// serial_slave module: top level of the serial bus slave
`timescale 1ns/1ps

module serial_slave #(
    parameter bus_frame_pkg::slave_id_t SLAVE_ID = 2'd1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic ready
);
    import bus_frame_pkg::*;
    import slave_ctrl_pkg::*;

    bus_cmd_t cmd;
    logic     cmd_valid;
    logic     busy;
    logic     accept;
    data_t    word;
    logic     word_done;
    logic     load;
    data_t    load_data;
    logic     word_sent;
    mem_req_t mem_req;
    data_t    rdata;

    config_receiver #(
        .SLAVE_ID(SLAVE_ID)
    ) config_receiver_i (
        .clk(clk), .rstN(rstN), .control(control), .busy(busy),
        .cmd(cmd), .cmd_valid(cmd_valid)
    );

    transfer_ctrl transfer_ctrl_i (
        .clk(clk), .rstN(rstN), .cmd(cmd), .cmd_valid(cmd_valid),
        .last(last), .valid(valid), .word(word), .word_done(word_done),
        .rdata(rdata), .word_sent(word_sent), .busy(busy), .ready(ready),
        .accept(accept), .load(load), .load_data(load_data), .mem_req(mem_req)
    );

    write_deserializer write_deserializer_i (
        .clk(clk), .rstN(rstN), .wD(wD), .accept(accept),
        .word(word), .word_done(word_done)
    );

    read_serializer read_serializer_i (
        .clk(clk), .rstN(rstN), .load(load), .load_data(load_data),
        .rD(rD), .word_sent(word_sent)
    );

    slave_memory slave_memory_i (
        .clk(clk), .mem_req(mem_req), .rdata(rdata)
    );

endmodule

//--- hw/serial_slave_defines.svh
// word width, memory depth, slave id width and frame start code
`ifndef SERIAL_SLAVE_DEFINES_SVH
`define SERIAL_SLAVE_DEFINES_SVH

// bits per memory word, also bits per serial data word
`define DATA_WIDTH 32

// number of words in the slave memory, kept a power of two
`define ADDR_DEPTH 2048

// width of the slave id field in the config frame
`define SLAVE_ID_WIDTH 2

// pattern that opens every config frame
`define START_CODE 3'b111

`endif

//--- hw/slave_ctrl_pkg.sv
// transfer FSM state enum and memory request struct
package slave_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        FETCH,
        SEND
    } ctrl_state_t;

    // single port request, rdata follows one cycle after a read
    typedef struct packed {
        logic                 en;
        logic                 we;
        bus_frame_pkg::addr_t addr;
        bus_frame_pkg::data_t wdata;
    } mem_req_t;

endpackage

//--- hw/slave_memory.sv
// single port word RAM with registered read
`timescale 1ns/1ps
`include "serial_slave_defines.svh"

module slave_memory (
    input  logic                     clk,
    input  slave_ctrl_pkg::mem_req_t mem_req,
    output bus_frame_pkg::data_t     rdata
);
    import bus_frame_pkg::*;

    // contents undefined until written
    data_t mem [`ADDR_DEPTH];

    always_ff @(posedge clk) begin
        if (mem_req.en) begin
            if (mem_req.we) begin
                mem[mem_req.addr] <= mem_req.wdata;
            end else begin
                rdata <= mem[mem_req.addr];
            end
        end
    end

    // controller must qualify every write with enable
    a_we_needs_en: assert property (
        @(posedge clk) mem_req.we |-> mem_req.en
    );

endmodule

//--- hw/transfer_ctrl.sv
// transfer_ctrl module: FSM for single and burst reads and writes
`timescale 1ns/1ps

module transfer_ctrl (
    input  logic                     clk,
    input  logic                     rstN,
    input  bus_frame_pkg::bus_cmd_t  cmd,
    input  logic                     cmd_valid,
    input  logic                     last,
    input  logic                     valid,
    input  bus_frame_pkg::data_t     word,
    input  logic                     word_done,
    input  bus_frame_pkg::data_t     rdata,
    input  logic                     word_sent,
    output logic                     busy,
    output logic                     ready,
    output logic                     accept,
    output logic                     load,
    output bus_frame_pkg::data_t     load_data,
    output slave_ctrl_pkg::mem_req_t mem_req
);
    import bus_frame_pkg::*;
    import slave_ctrl_pkg::*;

    ctrl_state_t state;
    addr_t       addr;
    addr_t       addr_next;
    logic        burst;
    logic        last_seen;
    logic        rd_pending;
    logic        write_more;
    logic        read_more;

    // address wraps at the memory depth
    assign addr_next = addr + 1'b1;

    // write word bits are all in before word_done
    assign write_more = burst && !last_seen;
    // a read word's final bit cycle still counts toward last
    assign read_more  = burst && !(last_seen || last);

    assign busy      = (state != IDLE);
    assign ready     = (state == WRITE) || (state == SEND);
    assign accept    = (state == WRITE) && valid;
    assign load      = (state == FETCH) && rd_pending;
    assign load_data = rdata;

    always_comb begin
        mem_req.en    = 1'b0;
        mem_req.we    = 1'b0;
        mem_req.addr  = addr;
        mem_req.wdata = word;
        case (state)
            WRITE: begin
                if (word_done) begin
                    mem_req.en = 1'b1;
                    mem_req.we = 1'b1;
                end
            end
            FETCH: begin
                mem_req.en = !rd_pending;
            end
            SEND: begin
                // prefetch under the final bit of the current word
                if (word_sent && read_more) begin
                    mem_req.en   = 1'b1;
                    mem_req.addr = addr_next;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= IDLE;
            addr       <= '0;
            burst      <= 1'b0;
            last_seen  <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        addr       <= cmd.addr;
                        burst      <= cmd.burst;
                        last_seen  <= 1'b0;
                        rd_pending <= 1'b0;
                        state      <= cmd.rw ? WRITE : FETCH;
                    end
                end
                WRITE: begin
                    if (word_done) begin
                        // an accept here already belongs to the next word
                        last_seen <= accept && last;
                        if (write_more) begin
                            addr <= addr_next;
                        end else begin
                            state <= IDLE;
                        end
                    end else if (accept && last) begin
                        last_seen <= 1'b1;
                    end
                end
                FETCH: begin
                    // issue cycle, then load cycle
                    rd_pending <= !rd_pending;
                    if (rd_pending) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (word_sent) begin
                        last_seen <= 1'b0;
                        if (read_more) begin
                            addr       <= addr_next;
                            rd_pending <= 1'b1;
                            state      <= FETCH;
                        end else begin
                            state <= IDLE;
                        end
                    end else if (last) begin
                        last_seen <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/write_deserializer.sv
// write_deserializer module: accepted wD bits collected into words
`timescale 1ns/1ps
`include "serial_slave_defines.svh"

module write_deserializer (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 wD,
    input  logic                 accept,
    output bus_frame_pkg::data_t word,
    output logic                 word_done
);
    import bus_frame_pkg::*;

    bit_count_t bit_cnt;
    logic       final_bit;

    assign final_bit = accept && (bit_cnt == bit_count_t'(`DATA_WIDTH - 1));

    // MSB arrives first, so shift toward the top
    always_ff @(posedge clk) begin
        if (accept) begin
            word <= {word[`DATA_WIDTH-2:0], wD};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt   <= '0;
            word_done <= 1'b0;
        end else begin
            word_done <= final_bit;
            if (final_bit) begin
                bit_cnt <= '0;
            end else if (accept) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // a word needs DATA_WIDTH accepts, so done never repeats
    a_done_single_pulse: assert property (
        @(posedge clk) disable iff (!rstN) word_done |=> !word_done
    );

endmodule

//--- list.f
+incdir+hw
hw/bus_frame_pkg.sv
hw/slave_ctrl_pkg.sv
hw/config_receiver.sv
hw/write_deserializer.sv
hw/read_serializer.sv
hw/slave_memory.sv
hw/transfer_ctrl.sv
hw/serial_slave.sv
testbench/tb_clock_gen.sv
testbench/serial_slave_tb.sv

//--- testbench/serial_slave_tb.sv
// random transfers checked against a memory model
`timescale 1ns/1ps
`include "serial_slave_defines.svh"

module serial_slave_tb;
    import bus_frame_pkg::*;

    localparam slave_id_t SLAVE_ID = 2'd1;
    localparam int WAIT_LIMIT = 200;
    localparam int NUM_TRANS = 24;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic ready;

    logic [31:0] rng_state;
    int          value_errors;
    int          timeout_errors;
    data_t       model [addr_t];
    addr_t       written [$];

    tb_clock_gen #(.PERIOD_NS(40)) tb_clock_gen_i (.clk(clk));

    serial_slave #(.SLAVE_ID(SLAVE_ID)) serial_slave_i (
        .clk(clk), .rstN(rstN), .control(control), .wD(wD),
        .valid(valid), .last(last), .rD(rD), .ready(ready)
    );

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic finish_run();
        $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: ready never came %s", what);
        timeout_errors++;
        finish_run();
    endtask

    // frame goes out MSB first at one bit per cycle
    task automatic drive_frame(input start_t start, input slave_id_t id, input logic rw,
                               input logic burst, input addr_t addr);
        bus_cmd_t frame;
        int i;
        frame = '{start: start, id: id, rw: rw, burst: burst, addr: addr};
        for (i = $bits(bus_cmd_t) - 1; i >= 0; i--) begin
            @(negedge clk);
            control = frame[i];
        end
        @(negedge clk);
        control = 1'b0;
    endtask

    task automatic wait_ready(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (ready !== level) begin
            if (cycles >= WAIT_LIMIT) begin
                abort_on_timeout(what);
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // ready and rD must stay low even with data offered on wD
    task automatic check_quiet(input int cycles, input logic offer_data);
        logic [31:0] r;
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge clk);
            r = next_random();
            valid = offer_data;
            wD = offer_data && r[0];
            if (ready !== 1'b0) begin
                $display("Fail ready: expected 0x0, got 0x%h at %0t", ready, $time);
                value_errors++;
            end
            if (rD !== 1'b0) begin
                $display("Fail rD: expected 0x0, got 0x%h at %0t", rD, $time);
                value_errors++;
            end
        end
        valid = 1'b0;
        wD = 1'b0;
    endtask

    task automatic write_words(input addr_t base, input int n, input logic burst);
        data_t data;
        int w;
        int bit_idx;
        int waited;
        drive_frame(`START_CODE, SLAVE_ID, 1'b1, burst, base);
        for (w = 0; w < n; w++) begin
            data = next_random();
            model[addr_t'(base + w)] = data;
            written.push_back(addr_t'(base + w));
            bit_idx = `DATA_WIDTH - 1;
            waited = 0;
            while (bit_idx >= 0) begin
                @(negedge clk);
                valid = 1'b0;
                last = 1'b0;
                // roughly one cycle in four is a valid gap
                if (ready && (next_random() % 4 != 0)) begin
                    valid = 1'b1;
                    wD = data[bit_idx];
                    last = burst && (w == n - 1);
                    bit_idx--;
                    waited = 0;
                end else if (waited >= WAIT_LIMIT) begin
                    abort_on_timeout("for a write bit");
                end else begin
                    waited++;
                end
            end
        end
        @(negedge clk);
        valid = 1'b0;
        last = 1'b0;
        wait_ready(1'b0, "to drop after a write");
    endtask

    task automatic read_words(input addr_t base, input int n, input logic burst);
        data_t got;
        data_t expected;
        int w;
        int b;
        drive_frame(`START_CODE, SLAVE_ID, 1'b0, burst, base);
        for (w = 0; w < n; w++) begin
            wait_ready(1'b1, "for a read word");
            // last only counts while ready is high
            last = burst && (w == n - 1);
            got = '0;
            for (b = 0; b < `DATA_WIDTH; b++) begin
                // the first bit was just seen with ready high
                if (b > 0) begin
                    @(negedge clk);
                    if (ready !== 1'b1) begin
                        $display("Fail ready: expected 0x1, got 0x%h in bit %0d", ready, b);
                        value_errors++;
                    end
                end
                got = {got[`DATA_WIDTH-2:0], rD};
            end
            expected = model[addr_t'(base + w)];
            if (got !== expected) begin
                $display("Fail rD: expected 0x%h, got 0x%h at addr 0x%h",
                         expected, got, addr_t'(base + w));
                value_errors++;
            end
            @(negedge clk);
            if (ready !== 1'b0) begin
                $display("Fail ready: expected 0x0, got 0x%h after word", ready);
                value_errors++;
            end
        end
        last = 1'b0;
        check_quiet(20, 1'b0);
    endtask

    initial begin
        addr_t a;
        int t;
        int n;
        int n_max;
        logic burst;
        rng_state = 32'd72;
        value_errors = 0;
        timeout_errors = 0;
        rstN = 1'b0;
        control = 1'b0;
        wD = 1'b0;
        valid = 1'b0;
        last = 1'b0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        check_quiet(20, 1'b0);

        a = addr_t'(next_random());
        write_words(a, 1, 1'b0);
        read_words(a, 1, 1'b0);

        for (t = 0; t < NUM_TRANS; t++) begin
            if (next_random() % 2 == 0) begin
                a = addr_t'(next_random());
                n = 1 + next_random() % 4;
                burst = (n > 1) || next_random() % 2;
                write_words(a, n, burst);
                read_words(a, n, burst);
            end else begin
                // only runs of written addresses are read
                a = written[next_random() % written.size()];
                n_max = 1 + next_random() % 4;
                n = 1;
                while (n < n_max && model.exists(addr_t'(a + n))) begin
                    n++;
                end
                burst = (n > 1) || next_random() % 2;
                read_words(a, n, burst);
            end
        end

        // foreign frames carry write data that must never land
        a = written[0];
        drive_frame(`START_CODE ^ 3'b010, SLAVE_ID, 1'b1, 1'b0, a);
        check_quiet(100, 1'b1);
        drive_frame(`START_CODE, 2'd2, 1'b1, 1'b0, a);
        check_quiet(100, 1'b1);
        read_words(a, 1, 1'b0);
        finish_run();
    end

endmodule

//--- testbench/tb_clock_gen.sv
// tb_clock_gen module: free running testbench clock
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    // half period high, half period low
    always begin
        #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule
